//--- source/isaPkg.sv
package isaPkg;

   // Datapath and instruction word width
   localparam int wordWidth = 16;
   // Eight architectural registers
   localparam int regAddrWidth = 3;
   // Immediate field of the I view
   localparam int immWidth = 5;

   // Word-addressed memories
   localparam int imemDepth = 32;
   localparam int dmemDepth = 32;
   localparam int imemAddrWidth = $clog2(imemDepth);
   localparam int dmemAddrWidth = $clog2(dmemDepth);

   // Primary opcodes in bits 15:11
   // Any code not listed traps as illegal
   typedef enum logic [4:0] {
      opHalt = 5'b00000,
      opNop  = 5'b00001,
      opJ    = 5'b00100,
      opAddi = 5'b01000,
      opBeqz = 5'b01100,
      opSt   = 5'b10000,
      opLd   = 5'b10001,
      opLbi  = 5'b11000,
      opAlu  = 5'b11011
   } opcode_t;

   // Register to register form
   // func picks the ALU function under opAlu
   typedef struct packed {
      opcode_t opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [regAddrWidth-1:0] rd;
      logic [1:0] func;
   } rFormat_t;

   // Immediate form
   // rd sits where rt sits in the R view, so ST reads its data through rt
   typedef struct packed {
      opcode_t opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rd;
      logic [immWidth-1:0] imm;
   } iFormat_t;

   // One fetched word, two ways to read it
   typedef union packed {
      rFormat_t r;
      iFormat_t i;
   } instrWord_t;

endpackage

//--- source/ctrlPkg.sv
package ctrlPkg;

   // ALU functions
   // Encoding matches the func field of opAlu
   typedef enum logic [1:0] {
      aluAdd = 2'b00,
      aluSub = 2'b01,
      aluAnd = 2'b10,
      aluXor = 2'b11
   } aluOp_t;

   // Source of the register writeback value
   typedef enum logic [1:0] {
      // ALU result
      wbAlu = 2'b00,
      // Data memory word for LD
      wbMem = 2'b01,
      // Sign-extended immediate for LBI
      wbImm = 2'b10
   } wbSrc_t;

   // Width of the aluOp field
   localparam int aluOpWidth = $bits(aluOp_t);

endpackage

//--- source/fetch.sv
module fetch (
   input  logic clk,
   input  logic rst,
   input  logic start,
   input  logic imemWrite,
   input  logic [isaPkg::imemAddrWidth-1:0] imemAddr,
   input  isaPkg::instrWord_t imemData,
   input  logic [isaPkg::imemAddrWidth-1:0] nextPc,
   input  logic stop,
   input  logic illegal,
   output isaPkg::instrWord_t instr,
   output logic [isaPkg::imemAddrWidth-1:0] pcInc,
   output logic running,
   output logic halted,
   output logic err
);
   import isaPkg::*;

   logic [imemAddrWidth-1:0] pc;
   // Program store, filled through the load strobe
   instrWord_t imem [imemDepth];

   // One word per load strobe
   always_ff @(posedge clk)
   begin
      if (imemWrite)
         imem[imemAddr] <= imemData;
   end

   // Asynchronous read of the current instruction
   assign instr = imem[pc];
   // Word addressed, so the next sequential PC is plus one
   assign pcInc = pc + 1'b1;

   // PC and run state
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc      <= '0;
         running <= 1'b0;
         halted  <= 1'b0;
         err     <= 1'b0;
      end
      else if (start)
      begin
         // Restart from address 0 with clean status
         pc      <= '0;
         running <= 1'b1;
         halted  <= 1'b0;
         err     <= 1'b0;
      end
      else if (running)
      begin
         pc <= nextPc;
         // HALT or trap ends the run
         if (stop)
         begin
            running <= 1'b0;
            halted  <= 1'b1;
            err     <= illegal;
         end
      end
   end

endmodule

//--- source/control.sv
module control (
   input  isaPkg::instrWord_t instr,
   input  logic running,
   output logic regWrite,
   output logic aluSrc,
   output ctrlPkg::aluOp_t aluOp,
   output ctrlPkg::wbSrc_t wbSel,
   output logic memWrite,
   output logic branch,
   output logic jump,
   output logic stop,
   output logic illegal
);
   import isaPkg::*;
   import ctrlPkg::*;

   always_comb
   begin
      // Idle core drives all lines low
      regWrite = 1'b0;
      aluSrc   = 1'b0;
      aluOp    = aluAdd;
      wbSel    = wbAlu;
      memWrite = 1'b0;
      branch   = 1'b0;
      jump     = 1'b0;
      stop     = 1'b0;
      illegal  = 1'b0;
      if (running)
      begin
         case (instr.r.opcode)
            opAlu:
            begin
               regWrite = 1'b1;
               // Function straight from the func field
               aluOp    = aluOp_t'(instr.r.func);
            end
            opAddi:
            begin
               regWrite = 1'b1;
               aluSrc   = 1'b1;
            end
            // Immediate bypasses the ALU
            opLbi:
            begin
               regWrite = 1'b1;
               wbSel    = wbImm;
            end
            // Address is rs plus imm
            opLd:
            begin
               regWrite = 1'b1;
               aluSrc   = 1'b1;
               wbSel    = wbMem;
            end
            opSt:
            begin
               aluSrc   = 1'b1;
               memWrite = 1'b1;
            end
            opBeqz: branch = 1'b1;
            opJ:    jump = 1'b1;
            opNop:  ;
            opHalt: stop = 1'b1;
            default:
            begin
               // Unknown opcode traps and stops the core
               illegal = 1'b1;
               stop    = 1'b1;
            end
         endcase
      end
   end

endmodule

//--- source/decode.sv
module decode (
   input  logic clk,
   input  logic rst,
   input  isaPkg::instrWord_t instr,
   input  logic regWrite,
   input  logic [isaPkg::wordWidth-1:0] writeData,
   output logic [isaPkg::wordWidth-1:0] rsData,
   output logic [isaPkg::wordWidth-1:0] rtData,
   output logic [isaPkg::wordWidth-1:0] immExt,
   output logic [isaPkg::regAddrWidth-1:0] wbReg
);
   import isaPkg::*;

   // Eight general registers, none hardwired
   logic [wordWidth-1:0] regs [2**regAddrWidth];

   // Destination field differs between the two views
   always_comb
   begin
      if (instr.r.opcode == opAlu)
         wbReg = instr.r.rd;
      else
         wbReg = instr.i.rd;
   end

   // Write at the edge that ends the instruction
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < 2**regAddrWidth; i++)
            regs[i] <= '0;
      end
      else if (regWrite)
      begin
         regs[wbReg] <= writeData;
      end
   end

   // Two read ports, combinational
   // rt also names the store data register of ST
   assign rsData = regs[instr.r.rs];
   assign rtData = regs[instr.r.rt];

   // Sign extend the 5-bit immediate
   assign immExt = {{(wordWidth - immWidth){instr.i.imm[immWidth-1]}}, instr.i.imm};

endmodule

//--- source/execute.sv
module execute (
   input  isaPkg::instrWord_t instr,
   input  logic [isaPkg::wordWidth-1:0] rsData,
   input  logic [isaPkg::wordWidth-1:0] rtData,
   input  logic [isaPkg::wordWidth-1:0] immExt,
   input  logic aluSrc,
   input  ctrlPkg::aluOp_t aluOp,
   input  logic branch,
   input  logic jump,
   input  logic [isaPkg::imemAddrWidth-1:0] pcInc,
   output logic [isaPkg::wordWidth-1:0] aluOut,
   output logic [isaPkg::imemAddrWidth-1:0] nextPc
);
   import isaPkg::*;
   import ctrlPkg::*;

   // Second ALU operand
   logic [wordWidth-1:0] aluB;
   // PC-relative offset at PC width
   logic [imemAddrWidth-1:0] pcOffset;
   // Condition for BEQZ
   logic rsZero;
   logic takeTarget;

   // Immediate for ADDI, LD and ST, register otherwise
   assign aluB = aluSrc ? immExt : rtData;

   always_comb
   begin
      aluOut = '0;
      case (aluOp)
         aluAdd: aluOut = rsData + aluB;
         // Two's complement wrap
         aluSub: aluOut = rsData - aluB;
         aluAnd: aluOut = rsData & aluB;
         aluXor: aluOut = rsData ^ aluB;
         default: aluOut = '0;
      endcase
   end

   // Offset taken from the I view and sign extended to the PC width
   assign pcOffset = imemAddrWidth'(signed'(instr.i.imm));

   // Full 16-bit compare against zero
   assign rsZero = (rsData == '0);

   // Jump always, branch only on zero
   assign takeTarget = jump | (branch & rsZero);

   // Target is relative to the following instruction
   always_comb
   begin
      if (takeTarget)
         nextPc = pcInc + pcOffset;
      else
         nextPc = pcInc;
   end

endmodule

//--- source/memAccess.sv
module memAccess (
   input  logic clk,
   input  logic rst,
   input  logic [isaPkg::wordWidth-1:0] aluOut,
   input  logic [isaPkg::wordWidth-1:0] rtData,
   input  logic [isaPkg::wordWidth-1:0] immExt,
   input  logic memWrite,
   input  ctrlPkg::wbSrc_t wbSel,
   output logic [isaPkg::wordWidth-1:0] writeData
);
   import isaPkg::*;
   import ctrlPkg::*;

   logic [wordWidth-1:0] dmem [dmemDepth];
   // Low bits of rs plus imm select the word
   logic [dmemAddrWidth-1:0] addr;
   logic [wordWidth-1:0] memData;

   assign addr = aluOut[dmemAddrWidth-1:0];

   // Cleared on reset so unwritten words read zero
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < dmemDepth; i++)
            dmem[i] <= '0;
      end
      else if (memWrite)
      begin
         dmem[addr] <= rtData;
      end
   end

   // Read in the same cycle for LD
   assign memData = dmem[addr];

   // Writeback select
   always_comb
   begin
      case (wbSel)
         wbMem:   writeData = memData;
         wbImm:   writeData = immExt;
         default: writeData = aluOut;
      endcase
   end

endmodule

//--- source/proc.sv
module proc (
   input  logic clk,
   input  logic rst,
   input  logic start,
   input  logic imemWrite,
   input  logic [isaPkg::imemAddrWidth-1:0] imemAddr,
   input  isaPkg::instrWord_t imemData,
   output logic wbValid,
   output logic [isaPkg::regAddrWidth-1:0] wbReg,
   output logic [isaPkg::wordWidth-1:0] wbData,
   output logic halted,
   output logic err
);
   import isaPkg::*;
   import ctrlPkg::*;

   // Fetch side
   instrWord_t instr;
   logic [imemAddrWidth-1:0] pcInc;
   logic [imemAddrWidth-1:0] nextPc;
   logic running;

   // Control lines
   logic aluSrc;
   aluOp_t aluOp;
   wbSrc_t wbSel;
   logic memWrite;
   logic branch;
   logic jump;
   logic stop;
   logic illegal;

   // Operands and results
   logic [wordWidth-1:0] rsData;
   logic [wordWidth-1:0] rtData;
   logic [wordWidth-1:0] immExt;
   logic [wordWidth-1:0] aluOut;

   // PC, run state and instruction memory
   // Illegal flag comes back here to become the sticky err
   fetch fetchStage (
      .clk(clk), .rst(rst), .start(start),
      .imemWrite(imemWrite), .imemAddr(imemAddr), .imemData(imemData),
      .nextPc(nextPc), .stop(stop), .illegal(illegal),
      .instr(instr), .pcInc(pcInc), .running(running),
      .halted(halted), .err(err)
   );

   // Register write strobe doubles as the observed wbValid
   control ctrlUnit (
      .instr(instr), .running(running),
      .regWrite(wbValid), .aluSrc(aluSrc), .aluOp(aluOp), .wbSel(wbSel),
      .memWrite(memWrite), .branch(branch), .jump(jump),
      .stop(stop), .illegal(illegal)
   );

   decode decodeStage (
      .clk(clk), .rst(rst), .instr(instr),
      .regWrite(wbValid), .writeData(wbData),
      .rsData(rsData), .rtData(rtData), .immExt(immExt), .wbReg(wbReg)
   );

   execute executeStage (
      .instr(instr), .rsData(rsData), .rtData(rtData), .immExt(immExt),
      .aluSrc(aluSrc), .aluOp(aluOp), .branch(branch), .jump(jump),
      .pcInc(pcInc), .aluOut(aluOut), .nextPc(nextPc)
   );

   // Writeback value goes back to the register file and out the top
   memAccess memStage (
      .clk(clk), .rst(rst), .aluOut(aluOut), .rtData(rtData), .immExt(immExt),
      .memWrite(memWrite), .wbSel(wbSel), .writeData(wbData)
   );

endmodule

//--- sim/proc_sva.sv
module procSva (
   input logic clk,
   input logic rst,
   input logic imemWrite,
   input logic running,
   input logic wbValid,
   input logic halted,
   input logic err
);
   timeunit 1ns;
   timeprecision 1ps;

   // No register write once the core has stopped
   wbAfterHalt: assert property (
      @(posedge clk) disable iff (rst)
      halted |-> !wbValid
   ) else $error("register write seen while halted");

   // A trap always stops the core
   errNeedsHalt: assert property (
      @(posedge clk) disable iff (rst)
      err |-> halted
   ) else $error("err high without halted");

   // Program store is only written while idle
   noLoadWhileRunning: assert property (
      @(posedge clk) disable iff (rst)
      running |-> !imemWrite
   ) else $error("instruction memory written while running");

endmodule

//--- sim/procTb.sv
module procTb;
   timeunit 1ns;
   timeprecision 1ps;
   import isaPkg::*;

   localparam int numTests = 5;
   localparam int resetCycles = 8;
   localparam int idleCycles = 3;

   logic clk;
   logic rst;
   logic start;
   logic imemWrite;
   logic [imemAddrWidth-1:0] imemAddr;
   instrWord_t imemData;
   logic wbValid;
   logic [regAddrWidth-1:0] wbReg;
   logic [wordWidth-1:0] wbData;
   logic halted;
   logic err;

   // Test table, one program per row
   logic [wordWidth-1:0] progMem [numTests][imemDepth];
   int progLen [numTests];
   bit errTab [numTests];
   string nameTab [numTests];

   // Writebacks predicted by the ISA model
   logic [regAddrWidth-1:0] expReg [$];
   logic [wordWidth-1:0] expData [$];

   int errorCount = 0;
   int checksDone = 0;
   int passCount = 0;
   int failCount = 0;
   int cycleCount = 0;
   int cycleLimit = 0;
   string curName;

   proc dut (
      .clk(clk), .rst(rst), .start(start),
      .imemWrite(imemWrite), .imemAddr(imemAddr), .imemData(imemData),
      .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
      .halted(halted), .err(err)
   );

   bind proc procSva sva (
      .clk(clk), .rst(rst), .imemWrite(imemWrite), .running(running),
      .wbValid(wbValid), .halted(halted), .err(err)
   );

   always #4 clk = ~clk;

   // Run limit guard
   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleLimit != 0 && cycleCount >= cycleLimit)
      begin
         $display("Timeout: test %s did not halt within %0d cycles", curName, cycleLimit);
         $display("Result: FAILED");
         $finish;
      end
   end

   function automatic logic [wordWidth-1:0] rType(opcode_t op, int rs, int rt, int rd, int f);
      return {op, 3'(rs), 3'(rt), 3'(rd), 2'(f)};
   endfunction

   function automatic logic [wordWidth-1:0] iType(opcode_t op, int rs, int rd, int imm);
      return {op, 3'(rs), 3'(rd), 5'(imm)};
   endfunction

   task automatic addWord(input int t, input logic [wordWidth-1:0] w);
      progMem[t][progLen[t]] = w;
      progLen[t]++;
   endtask

   task automatic checkWb(input logic [regAddrWidth-1:0] gotReg,
                          input logic [regAddrWidth-1:0] wantReg,
                          input logic [wordWidth-1:0] gotData,
                          input logic [wordWidth-1:0] wantData);
      checksDone++;
      if (gotReg !== wantReg || gotData !== wantData)
      begin
         errorCount++;
         $display("FAILED %0t: %s writeback r%0d=%h, expected r%0d=%h",
                  $time, curName, gotReg, gotData, wantReg, wantData);
      end
   endtask

   task automatic checkStatus(input logic gotHalted, input logic gotErr,
                              input logic wantHalted, input logic wantErr);
      checksDone++;
      if (gotHalted !== wantHalted || gotErr !== wantErr)
      begin
         errorCount++;
         $display("FAILED %0t: %s status halted=%b err=%b, expected halted=%b err=%b",
                  $time, curName, gotHalted, gotErr, wantHalted, wantErr);
      end
   endtask

   task automatic checkCount(input int got, input int want, input string what);
      checksDone++;
      if (got != want)
      begin
         errorCount++;
         $display("FAILED %0t: %s %s count %0d, expected %0d", $time, curName, what, got, want);
      end
   endtask

   // Random LBI operands and the fixed program shapes
   task automatic buildTable();
      int a;
      int b;
      int c;
      foreach (progMem[t, i])
         progMem[t][i] = '0;
      foreach (progLen[t])
         progLen[t] = 0;
      a = int'($urandom % 32);
      b = int'($urandom % 32);
      c = int'($urandom % 32);
      nameTab[0] = "alu";
      errTab[0] = 1'b0;
      addWord(0, iType(opLbi, 0, 1, a));
      addWord(0, iType(opLbi, 0, 2, b));
      addWord(0, rType(opAlu, 1, 2, 3, 0));
      addWord(0, rType(opAlu, 1, 2, 4, 1));
      addWord(0, rType(opAlu, 1, 2, 5, 2));
      addWord(0, rType(opAlu, 1, 2, 6, 3));
      addWord(0, iType(opAddi, 1, 7, c));
      addWord(0, iType(opHalt, 0, 0, 0));
      // Store then load back, plus one untouched word
      // Stored value never zero, so it differs from a cleared word
      nameTab[1] = "memory";
      errTab[1] = 1'b0;
      addWord(1, iType(opLbi, 0, 1, 1 + int'($urandom % 15)));
      addWord(1, iType(opLbi, 0, 2, int'($urandom % 32)));
      addWord(1, iType(opSt, 2, 1, 3));
      addWord(1, iType(opLd, 2, 3, 3));
      addWord(1, iType(opLd, 2, 4, 5));
      addWord(1, iType(opHalt, 0, 0, 0));
      // r1 zero, r2 never zero
      nameTab[2] = "branch";
      errTab[2] = 1'b0;
      addWord(2, iType(opLbi, 0, 1, 0));
      addWord(2, iType(opLbi, 0, 2, 1 + int'($urandom % 15)));
      addWord(2, iType(opBeqz, 1, 0, 1));
      addWord(2, iType(opLbi, 0, 3, 7));
      addWord(2, iType(opBeqz, 2, 0, 1));
      addWord(2, iType(opLbi, 0, 4, 5));
      addWord(2, iType(opJ, 0, 0, 1));
      addWord(2, iType(opLbi, 0, 5, 9));
      addWord(2, iType(opAddi, 2, 6, 1));
      addWord(2, iType(opNop, 0, 0, 0));
      addWord(2, iType(opHalt, 0, 0, 0));
      nameTab[3] = "halt";
      errTab[3] = 1'b0;
      addWord(3, iType(opLbi, 0, 1, int'($urandom % 32)));
      addWord(3, iType(opHalt, 0, 0, 0));
      addWord(3, iType(opLbi, 0, 2, 3));
      // Opcode 5'b11111 is not in the ISA
      nameTab[4] = "illegal";
      errTab[4] = 1'b1;
      addWord(4, iType(opLbi, 0, 1, int'($urandom % 32)));
      addWord(4, 16'hF800);
      addWord(4, iType(opLbi, 0, 2, 3));
   endtask

   // ISA reference, runs one program from a clean machine
   task automatic runModel(input int t);
      logic [wordWidth-1:0] regs [8];
      logic [wordWidth-1:0] mem [dmemDepth];
      logic [wordWidth-1:0] w;
      logic [wordWidth-1:0] imm;
      logic [wordWidth-1:0] sum;
      logic [wordWidth-1:0] val;
      logic [regAddrWidth-1:0] dst;
      logic [imemAddrWidth-1:0] pc;
      bit wr;
      bit done;
      int steps;
      expReg.delete();
      expData.delete();
      foreach (regs[i])
         regs[i] = '0;
      foreach (mem[i])
         mem[i] = '0;
      pc = '0;
      done = 1'b0;
      steps = 0;
      while (!done && steps < 2 * imemDepth)
      begin
         w = progMem[t][pc];
         imm = {{(wordWidth - immWidth){w[4]}}, w[4:0]};
         sum = regs[w[10:8]] + imm;
         // Targets are relative to the next word
         pc = pc + 1'b1;
         steps++;
         wr = 1'b0;
         dst = w[7:5];
         val = '0;
         case (w[15:11])
            opAlu:
            begin
               wr = 1'b1;
               dst = w[4:2];
               case (w[1:0])
                  2'd0: val = regs[w[10:8]] + regs[w[7:5]];
                  2'd1: val = regs[w[10:8]] - regs[w[7:5]];
                  2'd2: val = regs[w[10:8]] & regs[w[7:5]];
                  2'd3: val = regs[w[10:8]] ^ regs[w[7:5]];
               endcase
            end
            opAddi:
            begin
               wr = 1'b1;
               val = sum;
            end
            opLbi:
            begin
               wr = 1'b1;
               val = imm;
            end
            opLd:
            begin
               wr = 1'b1;
               val = mem[sum[dmemAddrWidth-1:0]];
            end
            opSt: mem[sum[dmemAddrWidth-1:0]] = regs[w[7:5]];
            opBeqz:
            begin
               if (regs[w[10:8]] == '0)
                  pc = pc + w[4:0];
            end
            opJ: pc = pc + w[4:0];
            opNop: ;
            // HALT and unknown codes both end the run
            default: done = 1'b1;
         endcase
         if (wr)
         begin
            regs[dst] = val;
            expReg.push_back(dst);
            expData.push_back(val);
         end
      end
   endtask

   // Reset, then idle with everything low
   task automatic resetCore();
      int idleWb;
      idleWb = 0;
      @(posedge clk);
      rst <= 1'b1;
      repeat (resetCycles) @(posedge clk);
      rst <= 1'b0;
      repeat (idleCycles)
      begin
         @(negedge clk);
         if (wbValid)
            idleWb++;
      end
      checkCount(idleWb, 0, "idle writeback");
      checkStatus(halted, err, 1'b0, 1'b0);
   endtask

   task automatic loadProgram(input int t);
      for (int i = 0; i < progLen[t]; i++)
      begin
         @(posedge clk);
         imemWrite <= 1'b1;
         imemAddr <= imemAddrWidth'(i);
         imemData <= progMem[t][i];
      end
      @(posedge clk);
      imemWrite <= 1'b0;
   endtask

   task automatic pulseStart();
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
   endtask

   task automatic runTest(input int t);
      int errBefore;
      int seen;
      errBefore = errorCount;
      curName = nameTab[t];
      runModel(t);
      resetCore();
      loadProgram(t);
      pulseStart();
      seen = 0;
      // Writebacks are sampled mid-cycle
      do
      begin
         @(negedge clk);
         if (wbValid)
         begin
            if (seen < expReg.size())
               checkWb(wbReg, expReg[seen], wbData, expData[seen]);
            seen++;
         end
      end while (!halted);
      // Stopped core must stay quiet
      repeat (idleCycles)
      begin
         @(negedge clk);
         if (wbValid)
            seen++;
      end
      checkStatus(halted, err, 1'b1, errTab[t]);
      checkCount(seen, expReg.size(), "writeback");
      if (errorCount == errBefore)
      begin
         passCount++;
         $display("test %0d (%s): pass, %0d writebacks", t, curName, seen);
      end
      else
      begin
         failCount++;
         $display("test %0d (%s): fail, %0d errors", t, curName, errorCount - errBefore);
      end
   endtask

   initial
   begin
      clk = 1'b0;
      rst = 1'b1;
      start = 1'b0;
      imemWrite = 1'b0;
      imemAddr = '0;
      imemData = '0;
      void'($urandom(32'h4ace));
      buildTable();
      // Reset, idle, load and run per program, doubled
      for (int t = 0; t < numTests; t++)
         cycleLimit += 2 * (2 * progLen[t] + resetCycles + 2 * idleCycles + 6);
      for (int t = 0; t < numTests; t++)
         runTest(t);
      $display("Tests: %0d run, %0d passed, %0d failed; checks %0d, errors %0d",
               numTests, passCount, failCount, checksDone, errorCount);
      if (errorCount == 0)
      begin
         $display("Result: PASSED");
      end
      else
      begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- filelist.f
source/isaPkg.sv
source/ctrlPkg.sv
source/fetch.sv
source/control.sv
source/decode.sv
source/execute.sv
source/memAccess.sv
source/proc.sv
sim/proc_sva.sv
sim/procTb.sv

//--- run.sh
#!/bin/sh
# Build and run the processor testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module procTb -Mdir obj_dir -o procSim -f filelist.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/procSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# Verdict comes from the log
if grep -q "Result: FAILED" "$LOG"; then
   echo "Simulation reported failure"
   exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
   echo "Simulation ended without a verdict"
   exit 1
fi
exit 0
